// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hazard_detector
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
hw/hazard_pkg.sv
hw/stage_write_decode.sv
hw/operand_read_decode.sv
hw/hazard_match.sv
hw/pipe_stall_ctrl.sv
hw/hazard_detector.sv
verif/tb_hazard_detector.sv

// ==== hw/hazard_detector.sv ====
// hazard detector top, takes the ID/EXE/MEM/WB snapshot and drives the pipeline register controls
`timescale 1ns/100ps

module hazard_detector (
    input  hazard_pkg::id_stage_t  id,
    input  hazard_pkg::exe_stage_t exe,
    input  hazard_pkg::mem_stage_t mem,
    input  hazard_pkg::wb_stage_t  wb,
    input  logic                   if_redirect,
    input  logic                   mem_ok,
    input  logic                   if_ok,
    output hazard_pkg::pipe_ctrl_t ctrl
);

    hazard_pkg::stage_writes_t  exe_wr;
    hazard_pkg::stage_writes_t  mem_wr;
    hazard_pkg::stage_writes_t  wb_wr;
    hazard_pkg::operand_reads_t reads;
    hazard_pkg::hazard_t        haz;
    logic                       id_fence_i;
    logic                       id_ebreak;

    stage_write_decode u_exe_wr (
        .valid  (exe.valid),
        .wb_op  (exe.wb_op),
        .rd     (exe.rd),
        .csr    (exe.csr),
        .writes (exe_wr)
    );

    stage_write_decode u_mem_wr (
        .valid  (mem.valid),
        .wb_op  (mem.wb_op),
        .rd     (mem.rd),
        .csr    (mem.csr),
        .writes (mem_wr)
    );

    stage_write_decode u_wb_wr (
        .valid  (wb.valid),
        .wb_op  (wb.wb_op),
        .rd     (wb.rd),
        .csr    (wb.csr),
        .writes (wb_wr)
    );

    operand_read_decode u_reads (
        .id         (id),
        .exe        (exe),
        .mem        (mem),
        .reads      (reads),
        .id_fence_i (id_fence_i),
        .id_ebreak  (id_ebreak)
    );

    hazard_match u_match (
        .reads  (reads),
        .id     (id),
        .exe    (exe),
        .mem    (mem),
        .exe_wr (exe_wr),
        .mem_wr (mem_wr),
        .wb_wr  (wb_wr),
        .haz    (haz)
    );

    pipe_stall_ctrl u_stall (
        .haz          (haz),
        .id_valid     (id.valid),
        .exe_valid    (exe.valid),
        .mem_valid_in (mem.valid),
        .id_fence_i   (id_fence_i),
        .id_ebreak    (id_ebreak),
        .if_redirect  (if_redirect),
        .mem_ok       (mem_ok),
        .if_ok        (if_ok),
        .ctrl         (ctrl)
    );

endmodule

// ==== hw/hazard_match.sv ====
// compares the operand reads of ID, EXE and MEM against writes still in flight
`timescale 1ns/100ps

module hazard_match (
    input  hazard_pkg::operand_reads_t reads,
    input  hazard_pkg::id_stage_t      id,
    input  hazard_pkg::exe_stage_t     exe,
    input  hazard_pkg::mem_stage_t     mem,
    input  hazard_pkg::stage_writes_t  exe_wr,
    input  hazard_pkg::stage_writes_t  mem_wr,
    input  hazard_pkg::stage_writes_t  wb_wr,
    output hazard_pkg::hazard_t        haz
);

    function automatic logic rd_hit(input hazard_pkg::reg_addr_t rs,
                                    input hazard_pkg::stage_writes_t wr);
        return wr.rd_write && (rs == wr.rd); // x0 not filtered
    endfunction

    function automatic logic csr_hit(input hazard_pkg::csr_addr_t addr,
                                     input hazard_pkg::stage_writes_t wr);
        return wr.csr_write && (addr == wr.csr);
    endfunction

    logic id_rs1_hit;
    logic id_rs2_hit;
    logic id_mtvec_hit;
    logic id_mepc_hit;
    logic exe_rs1_hit;
    logic exe_rs2_hit;
    logic exe_csr_hit;
    logic exe_trap_csr;
    logic exe_trap_hit;
    logic mem_rs2_hit;

    // ID reads against EXE, MEM and WB
    assign id_rs1_hit = reads.id_rs1
                     && (rd_hit(id.rs1, exe_wr)
                      || rd_hit(id.rs1, mem_wr)
                      || rd_hit(id.rs1, wb_wr));

    assign id_rs2_hit = reads.id_rs2
                     && (rd_hit(id.rs2, exe_wr)
                      || rd_hit(id.rs2, mem_wr)
                      || rd_hit(id.rs2, wb_wr));

    assign id_mtvec_hit = reads.id_mtvec
                       && (csr_hit(hazard_pkg::CSR_MTVEC, exe_wr)
                        || csr_hit(hazard_pkg::CSR_MTVEC, mem_wr)
                        || csr_hit(hazard_pkg::CSR_MTVEC, wb_wr));

    // a trap in flight rewrites mepc
    assign id_mepc_hit = reads.id_mepc
                      && (csr_hit(hazard_pkg::CSR_MEPC, exe_wr)
                       || csr_hit(hazard_pkg::CSR_MEPC, mem_wr)
                       || csr_hit(hazard_pkg::CSR_MEPC, wb_wr)
                       || exe_wr.trap_write
                       || mem_wr.trap_write
                       || wb_wr.trap_write);

    // EXE reads against MEM and WB only
    assign exe_rs1_hit = reads.exe_rs1
                      && (rd_hit(exe.rs1, mem_wr) || rd_hit(exe.rs1, wb_wr));

    assign exe_rs2_hit = reads.exe_rs2
                      && (rd_hit(exe.rs2, mem_wr) || rd_hit(exe.rs2, wb_wr));

    assign exe_csr_hit = reads.exe_csr
                      && (csr_hit(exe.csr, mem_wr) || csr_hit(exe.csr, wb_wr));

    assign exe_trap_csr = (exe.csr == hazard_pkg::CSR_MEPC)
                       || (exe.csr == hazard_pkg::CSR_MCAUSE)
                       || (exe.csr == hazard_pkg::CSR_MSTATUS);

    assign exe_trap_hit = reads.exe_csr && exe_trap_csr
                       && (mem_wr.trap_write || wb_wr.trap_write);

    // store data against WB
    assign mem_rs2_hit = reads.mem_rs2 && rd_hit(mem.rs2, wb_wr);

    always_comb begin
        haz.id_hazard  = id_rs1_hit || id_rs2_hit || id_mtvec_hit || id_mepc_hit;
        haz.exe_hazard = exe_rs1_hit || exe_rs2_hit || exe_csr_hit || exe_trap_hit;
        haz.mem_hazard = mem_rs2_hit;
    end

endmodule

// ==== hw/hazard_pkg.sv ====
// shared widths, opcode encodings and stage structs, referenced by scoped name in every RTL module
package hazard_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // op class seen by the hazard unit while the instruction sits in ID
    typedef enum logic [3:0] {
        ID_NONE, ID_BRANCH, ID_JALR, ID_ECALL,
        ID_EBREAK, ID_ILLEGAL, ID_MRET, ID_FENCE_I
    } id_op_e;

    typedef enum logic [4:0] {
        EXE_NOP, EXE_ADD, EXE_SUB, EXE_AND, EXE_OR, EXE_XOR,
        EXE_SLL, EXE_SRL, EXE_SRA, EXE_SLT, EXE_SLTU,
        EXE_MUL, EXE_DIV, EXE_REM
    } exe_op_e;

    typedef enum logic [2:0] {
        SRC_NONE, SRC_R_R, SRC_R_I, SRC_PC_I,
        SRC_R_CSR, SRC_NOTR_CSR, SRC_CSR_ZIMM, SRC_CSR_NOTZIMM
    } exe_src_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU,
        MEM_SB, MEM_SH, MEM_SW, MEM_SD
    } mem_op_e;

    typedef enum logic [3:0] {
        WB_NONE, WB_EXE, WB_MEM, WB_IMM, WB_SNPC,
        WB_CSRRW, WB_CSRRS, WB_CSRRWI,
        WB_ECALL, WB_EBREAK, WB_ILLEGAL
    } wb_op_e;

    typedef struct packed {
        logic      valid;
        id_op_e    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } id_stage_t;

    typedef struct packed {
        logic      valid;
        exe_op_e   op;
        exe_src_e  src;
        wb_op_e    wb_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        csr_addr_t csr;
    } exe_stage_t;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        wb_op_e    wb_op;
        reg_addr_t rd;
        reg_addr_t rs2;
        csr_addr_t csr;
    } mem_stage_t;

    typedef struct packed {
        logic      valid;
        wb_op_e    wb_op;
        reg_addr_t rd;
        csr_addr_t csr;
    } wb_stage_t;

    typedef struct packed {
        logic      rd_write;
        logic      csr_write;
        logic      trap_write; // mepc, mcause and mstatus
        reg_addr_t rd;
        csr_addr_t csr;
    } stage_writes_t;

    typedef struct packed {
        logic id_rs1;
        logic id_rs2;
        logic id_mtvec;
        logic id_mepc;
        logic exe_rs1;
        logic exe_rs2;
        logic exe_csr;
        logic mem_rs2;
    } operand_reads_t;

    typedef struct packed {
        logic id_hazard;
        logic exe_hazard;
        logic mem_hazard;
    } hazard_t;

    typedef struct packed {
        logic if_reg_enable;
        logic if_valid;
        logic id_reg_valid;
        logic id_reg_enable;
        logic exe_reg_valid;
        logic exe_reg_enable;
        logic mem_reg_valid;
        logic mem_valid;
        logic mem_reg_enable;
        logic wb_reg_valid;
    } pipe_ctrl_t;

endpackage

// ==== hw/operand_read_decode.sv ====
// works out which registers and CSRs the ID, EXE and MEM stages read this cycle
`timescale 1ns/100ps

module operand_read_decode (
    input  hazard_pkg::id_stage_t      id,
    input  hazard_pkg::exe_stage_t     exe,
    input  hazard_pkg::mem_stage_t     mem,
    output hazard_pkg::operand_reads_t reads,
    output logic                       id_fence_i,
    output logic                       id_ebreak
);

    logic exe_active;

    assign exe_active = exe.valid && (exe.op != hazard_pkg::EXE_NOP);

    assign id_fence_i = id.valid && (id.op == hazard_pkg::ID_FENCE_I);
    assign id_ebreak  = id.valid && (id.op == hazard_pkg::ID_EBREAK);

    // branch operands resolve in ID
    always_comb begin
        reads.id_rs1   = 1'b0;
        reads.id_rs2   = 1'b0;
        reads.id_mtvec = 1'b0;
        reads.id_mepc  = 1'b0;
        if (id.valid) begin
            reads.id_rs1   = (id.op == hazard_pkg::ID_BRANCH) || (id.op == hazard_pkg::ID_JALR);
            reads.id_rs2   = (id.op == hazard_pkg::ID_BRANCH);
            reads.id_mtvec = (id.op == hazard_pkg::ID_ECALL)
                          || (id.op == hazard_pkg::ID_EBREAK)
                          || (id.op == hazard_pkg::ID_ILLEGAL); // trap target
            reads.id_mepc  = (id.op == hazard_pkg::ID_MRET);
        end
    end

    always_comb begin
        reads.exe_rs1 = 1'b0;
        reads.exe_rs2 = 1'b0;
        reads.exe_csr = 1'b0;
        if (exe_active) begin
            case (exe.src)
                hazard_pkg::SRC_R_R: begin
                    reads.exe_rs1 = 1'b1;
                    reads.exe_rs2 = 1'b1;
                end
                hazard_pkg::SRC_R_I: begin
                    reads.exe_rs1 = 1'b1;
                end
                hazard_pkg::SRC_R_CSR,
                hazard_pkg::SRC_NOTR_CSR: begin
                    reads.exe_rs1 = 1'b1; // csrrw/csrrs/csrrc
                    reads.exe_csr = 1'b1;
                end
                hazard_pkg::SRC_CSR_ZIMM,
                hazard_pkg::SRC_CSR_NOTZIMM: begin
                    reads.exe_csr = 1'b1; // immediate forms
                end
                default: begin
                    reads.exe_rs1 = 1'b0;
                end
            endcase
        end
    end

    // store data is read in MEM
    always_comb begin
        reads.mem_rs2 = 1'b0;
        if (mem.valid) begin
            case (mem.op)
                hazard_pkg::MEM_SB,
                hazard_pkg::MEM_SH,
                hazard_pkg::MEM_SW,
                hazard_pkg::MEM_SD: reads.mem_rs2 = 1'b1;
                default:            reads.mem_rs2 = 1'b0;
            endcase
        end
    end

endmodule

// ==== hw/pipe_stall_ctrl.sv ====
// turns stage hazards, fence.i, redirect and back-pressure into pipeline register controls
`timescale 1ns/100ps

module pipe_stall_ctrl (
    input  hazard_pkg::hazard_t    haz,
    input  logic                   id_valid,
    input  logic                   exe_valid,
    input  logic                   mem_valid_in,
    input  logic                   id_fence_i,
    input  logic                   id_ebreak,
    input  logic                   if_redirect,
    input  logic                   mem_ok,
    input  logic                   if_ok,
    output hazard_pkg::pipe_ctrl_t ctrl
);

    logic fence_wait;
    logic redirect_kill;
    logic any_hazard;
    logic front_stall;

    // fence.i holds until EXE and MEM have drained
    assign fence_wait    = id_fence_i && (exe_valid || mem_valid_in);
    assign redirect_kill = id_valid && if_redirect;
    assign any_hazard    = haz.id_hazard || haz.exe_hazard || haz.mem_hazard;

    // a stall anywhere freezes everything in front of it
    assign front_stall = any_hazard || fence_wait || !mem_ok;

    always_comb begin
        // fetch side
        ctrl.if_reg_enable = !(front_stall || !if_ok);
        ctrl.if_valid      = !(redirect_kill || fence_wait);

        // decode side
        ctrl.id_reg_valid  = !redirect_kill;
        ctrl.id_reg_enable = !front_stall;

        // bubble into EXE
        ctrl.exe_reg_valid  = !(haz.id_hazard || id_fence_i || id_ebreak);
        ctrl.exe_reg_enable = !(haz.exe_hazard || haz.mem_hazard || !mem_ok);

        ctrl.mem_reg_valid  = !haz.exe_hazard; // bubble into MEM

        // store waits on WB, so MEM op and its result are held back
        ctrl.mem_valid      = !haz.mem_hazard;
        ctrl.mem_reg_enable = !(haz.mem_hazard || !mem_ok);
        ctrl.wb_reg_valid   = !haz.mem_hazard;
    end

endmodule

// ==== hw/stage_write_decode.sv ====
// decodes the write-back op of one later pipeline stage into its register, CSR and trap writes
`timescale 1ns/100ps

module stage_write_decode (
    input  logic                      valid,
    input  hazard_pkg::wb_op_e        wb_op,
    input  hazard_pkg::reg_addr_t     rd,
    input  hazard_pkg::csr_addr_t     csr,
    output hazard_pkg::stage_writes_t writes
);

    always_comb begin
        writes.rd         = rd;
        writes.csr        = csr;
        writes.rd_write   = 1'b0;
        writes.csr_write  = 1'b0;
        writes.trap_write = 1'b0;
        if (valid) begin
            case (wb_op)
                hazard_pkg::WB_NONE: begin
                    writes.rd_write = 1'b0; // bubble
                end
                hazard_pkg::WB_ECALL,
                hazard_pkg::WB_EBREAK,
                hazard_pkg::WB_ILLEGAL: begin
                    writes.trap_write = 1'b1; // no rd update on a trap
                end
                hazard_pkg::WB_CSRRW,
                hazard_pkg::WB_CSRRS,
                hazard_pkg::WB_CSRRWI: begin
                    writes.rd_write  = 1'b1; // old csr value goes to rd
                    writes.csr_write = 1'b1;
                end
                default: begin
                    writes.rd_write = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== verif/tb_hazard_detector.sv ====
// simulation top for the hazard detector that runs directed cases and an LFSR sweep against the stall rules
`timescale 1ns/100ps

module tb_hazard_detector;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 19;
    localparam int N_RANDOM     = 200;
    localparam int MARGIN       = 20;
    localparam hazard_pkg::pipe_ctrl_t CTRL_IDLE = '1;

    logic                   clk;
    logic                   rst_n;
    hazard_pkg::id_stage_t  id;
    hazard_pkg::exe_stage_t exe;
    hazard_pkg::mem_stage_t mem;
    hazard_pkg::wb_stage_t  wb;
    logic                   if_redirect;
    logic                   mem_ok;
    logic                   if_ok;
    hazard_pkg::pipe_ctrl_t ctrl;

    // snapshot that apply_vector drives next cycle
    hazard_pkg::id_stage_t  id_s;
    hazard_pkg::exe_stage_t exe_s;
    hazard_pkg::mem_stage_t mem_s;
    hazard_pkg::wb_stage_t  wb_s;
    logic                   redirect_s;
    logic                   mem_ok_s;
    logic                   if_ok_s;
    logic [31:0]            lfsr_state;

    hazard_detector hazard_detector_inst (
        .id          (id),
        .exe         (exe),
        .mem         (mem),
        .wb          (wb),
        .if_redirect (if_redirect),
        .mem_ok      (mem_ok),
        .if_ok       (if_ok),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
    end

    task automatic report_failure(input string why);
        $display("FAIL: see errors above");
        $fatal(1, "%s", why);
    endtask

    initial begin
        #((RESET_CYCLES + 1 + N_DIRECTED + N_RANDOM + MARGIN) * CLK_PERIOD);
        report_failure("timeout: tests did not finish");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic hazard_pkg::csr_addr_t pick_csr();
        case (3'(rand_bits(3)))
            3'd0:    return hazard_pkg::CSR_MTVEC;
            3'd1:    return hazard_pkg::CSR_MEPC;
            3'd2:    return hazard_pkg::CSR_MCAUSE;
            3'd3:    return hazard_pkg::CSR_MSTATUS;
            default: return 12'h340; // mscratch is not touched by a trap
        endcase
    endfunction

    function automatic hazard_pkg::stage_writes_t effect_of(input logic valid,
                                                            input hazard_pkg::wb_op_e op,
                                                            input hazard_pkg::reg_addr_t rd,
                                                            input hazard_pkg::csr_addr_t csr);
        hazard_pkg::stage_writes_t w;
        w.rd         = rd;
        w.csr        = csr;
        w.trap_write = valid && (op inside {hazard_pkg::WB_ECALL, hazard_pkg::WB_EBREAK,
                                            hazard_pkg::WB_ILLEGAL});
        w.csr_write  = valid && (op inside {hazard_pkg::WB_CSRRW, hazard_pkg::WB_CSRRS,
                                            hazard_pkg::WB_CSRRWI});
        w.rd_write   = valid && (op != hazard_pkg::WB_NONE) && !w.trap_write;
        return w;
    endfunction

    // expected controls straight from the stall rules
    function automatic hazard_pkg::pipe_ctrl_t model_ctrl(input hazard_pkg::id_stage_t id_v,
                                                          input hazard_pkg::exe_stage_t exe_v,
                                                          input hazard_pkg::mem_stage_t mem_v,
                                                          input hazard_pkg::wb_stage_t wb_v,
                                                          input logic redirect,
                                                          input logic mok,
                                                          input logic iok);
        hazard_pkg::stage_writes_t later [3];
        hazard_pkg::pipe_ctrl_t    c;
        logic id_r1;
        logic id_r2;
        logic id_tv;
        logic id_ep;
        logic ex_r1;
        logic ex_r2;
        logic ex_csr;
        logic trap_csr;
        logic store;
        logic id_h;
        logic exe_h;
        logic mem_h;
        logic fence;
        logic ebrk;
        logic fwait;
        logic kill;
        logic stall;
        int   s;
        later[0] = effect_of(exe_v.valid, exe_v.wb_op, exe_v.rd, exe_v.csr);
        later[1] = effect_of(mem_v.valid, mem_v.wb_op, mem_v.rd, mem_v.csr);
        later[2] = effect_of(wb_v.valid, wb_v.wb_op, wb_v.rd, wb_v.csr);
        id_r1 = id_v.valid && (id_v.op inside {hazard_pkg::ID_BRANCH, hazard_pkg::ID_JALR});
        id_r2 = id_v.valid && (id_v.op == hazard_pkg::ID_BRANCH);
        id_tv = id_v.valid && (id_v.op inside {hazard_pkg::ID_ECALL, hazard_pkg::ID_EBREAK,
                                               hazard_pkg::ID_ILLEGAL});
        id_ep = id_v.valid && (id_v.op == hazard_pkg::ID_MRET);
        ex_r1  = 1'b0;
        ex_r2  = 1'b0;
        ex_csr = 1'b0;
        if (exe_v.valid && exe_v.op != hazard_pkg::EXE_NOP) begin
            ex_r1  = exe_v.src inside {hazard_pkg::SRC_R_R, hazard_pkg::SRC_R_I,
                                       hazard_pkg::SRC_R_CSR, hazard_pkg::SRC_NOTR_CSR};
            ex_r2  = exe_v.src == hazard_pkg::SRC_R_R;
            ex_csr = exe_v.src inside {hazard_pkg::SRC_R_CSR, hazard_pkg::SRC_NOTR_CSR,
                                       hazard_pkg::SRC_CSR_ZIMM, hazard_pkg::SRC_CSR_NOTZIMM};
        end
        trap_csr = exe_v.csr inside {hazard_pkg::CSR_MEPC, hazard_pkg::CSR_MCAUSE,
                                     hazard_pkg::CSR_MSTATUS};
        store = mem_v.valid && (mem_v.op inside {hazard_pkg::MEM_SB, hazard_pkg::MEM_SH,
                                                 hazard_pkg::MEM_SW, hazard_pkg::MEM_SD});
        id_h  = 1'b0;
        exe_h = 1'b0;
        mem_h = 1'b0;
        for (s = 0; s < 3; s++) begin
            if (id_r1 && later[s].rd_write && id_v.rs1 == later[s].rd) id_h = 1'b1;
            if (id_r2 && later[s].rd_write && id_v.rs2 == later[s].rd) id_h = 1'b1;
            if (id_tv && later[s].csr_write && later[s].csr == hazard_pkg::CSR_MTVEC) id_h = 1'b1;
            if (id_ep && (later[s].trap_write
                          || (later[s].csr_write && later[s].csr == hazard_pkg::CSR_MEPC))) begin
                id_h = 1'b1;
            end
            if (s > 0) begin // EXE only waits on MEM and WB
                if (ex_r1 && later[s].rd_write && exe_v.rs1 == later[s].rd) exe_h = 1'b1;
                if (ex_r2 && later[s].rd_write && exe_v.rs2 == later[s].rd) exe_h = 1'b1;
                if (ex_csr && later[s].csr_write && exe_v.csr == later[s].csr) exe_h = 1'b1;
                if (ex_csr && trap_csr && later[s].trap_write) exe_h = 1'b1;
            end
            if (s == 2 && store && later[s].rd_write && mem_v.rs2 == later[s].rd) mem_h = 1'b1;
        end
        fence = id_v.valid && (id_v.op == hazard_pkg::ID_FENCE_I);
        ebrk  = id_v.valid && (id_v.op == hazard_pkg::ID_EBREAK);
        fwait = fence && (exe_v.valid || mem_v.valid);
        kill  = id_v.valid && redirect;
        stall = id_h || exe_h || mem_h || fwait || !mok;
        c.if_reg_enable  = !stall && iok;
        c.if_valid       = !(kill || fwait);
        c.id_reg_valid   = !kill;
        c.id_reg_enable  = !stall;
        c.exe_reg_valid  = !(id_h || fence || ebrk);
        c.exe_reg_enable = !(exe_h || mem_h || !mok);
        c.mem_reg_valid  = !exe_h;
        c.mem_valid      = !mem_h;
        c.mem_reg_enable = !(mem_h || !mok);
        c.wb_reg_valid   = !mem_h;
        return c;
    endfunction

    task automatic check_pipe_ctrl(input string name,
                                   input hazard_pkg::pipe_ctrl_t expected,
                                   input hazard_pkg::pipe_ctrl_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b actual %b", name, expected, actual);
            report_failure("pipeline controls differ from the expected value");
        end
    endtask

    task automatic clear_snapshot();
        id_s       = '0;
        exe_s      = '0;
        mem_s      = '0;
        wb_s       = '0;
        redirect_s = 1'b0;
        mem_ok_s   = 1'b1;
        if_ok_s    = 1'b1;
    endtask

    task automatic apply_vector(input string name, input hazard_pkg::pipe_ctrl_t expected);
        @(posedge clk);
        #(DRIVE_DLY);
        id          = id_s;
        exe         = exe_s;
        mem         = mem_s;
        wb          = wb_s;
        if_redirect = redirect_s;
        mem_ok      = mem_ok_s;
        if_ok       = if_ok_s;
        #(CLK_PERIOD - DRIVE_DLY - 2); // just ahead of the next edge
        check_pipe_ctrl(name, expected, ctrl);
    endtask

    task automatic idle_check();
        clear_snapshot();
        apply_vector("idle", CTRL_IDLE);
    endtask

    task automatic id_reg_hazards();
        hazard_pkg::pipe_ctrl_t stall;
        stall = '{if_reg_enable: 1'b0, id_reg_enable: 1'b0, exe_reg_valid: 1'b0, default: 1'b1};
        clear_snapshot();
        id_s.valid = 1'b1;
        id_s.op    = hazard_pkg::ID_BRANCH;
        id_s.rs1   = 5'd3;
        id_s.rs2   = 5'd4;
        exe_s.valid = 1'b1;
        exe_s.op    = hazard_pkg::EXE_ADD;
        exe_s.src   = hazard_pkg::SRC_PC_I; // reads nothing in EXE
        exe_s.wb_op = hazard_pkg::WB_EXE;
        exe_s.rd    = 5'd3;
        apply_vector("id_rs1_vs_exe", stall);
        exe_s.wb_op = hazard_pkg::WB_ECALL;
        apply_vector("id_trap_not_writer", CTRL_IDLE);
        exe_s.wb_op = hazard_pkg::WB_EXE;
        exe_s.valid = 1'b0;
        apply_vector("id_invalid_writer", CTRL_IDLE);
        mem_s.valid = 1'b1;
        mem_s.op    = hazard_pkg::MEM_LD;
        mem_s.wb_op = hazard_pkg::WB_MEM;
        mem_s.rd    = 5'd4;
        apply_vector("id_rs2_vs_mem", stall);
        clear_snapshot();
        id_s.valid = 1'b1;
        id_s.op    = hazard_pkg::ID_JALR;
        id_s.rs1   = 5'd3;
        wb_s.valid = 1'b1;
        wb_s.wb_op = hazard_pkg::WB_SNPC;
        wb_s.rd    = 5'd3;
        apply_vector("id_jalr_vs_wb", stall);
    endtask

    task automatic exe_mem_hazards();
        hazard_pkg::pipe_ctrl_t exe_stall;
        hazard_pkg::pipe_ctrl_t mem_stall;
        exe_stall = '{if_reg_enable: 1'b0, id_reg_enable: 1'b0, exe_reg_enable: 1'b0,
                      mem_reg_valid: 1'b0, default: 1'b1};
        mem_stall = '{if_reg_enable: 1'b0, id_reg_enable: 1'b0, exe_reg_enable: 1'b0,
                      mem_valid: 1'b0, mem_reg_enable: 1'b0, wb_reg_valid: 1'b0, default: 1'b1};
        clear_snapshot();
        exe_s.valid = 1'b1;
        exe_s.op    = hazard_pkg::EXE_ADD;
        exe_s.src   = hazard_pkg::SRC_R_R;
        exe_s.wb_op = hazard_pkg::WB_EXE;
        exe_s.rd    = 5'd9;
        exe_s.rs1   = 5'd5;
        exe_s.rs2   = 5'd6;
        mem_s.valid = 1'b1;
        mem_s.op    = hazard_pkg::MEM_LD;
        mem_s.wb_op = hazard_pkg::WB_MEM;
        mem_s.rd    = 5'd5;
        apply_vector("exe_rs1_vs_mem", exe_stall);
        clear_snapshot();
        exe_s.valid = 1'b1;
        exe_s.op    = hazard_pkg::EXE_ADD;
        exe_s.src   = hazard_pkg::SRC_CSR_ZIMM;
        exe_s.wb_op = hazard_pkg::WB_CSRRWI;
        exe_s.csr   = hazard_pkg::CSR_MEPC;
        wb_s.valid  = 1'b1;
        wb_s.wb_op  = hazard_pkg::WB_ECALL;
        apply_vector("exe_mepc_vs_wb_ecall", exe_stall);
        clear_snapshot();
        mem_s.valid = 1'b1;
        mem_s.op    = hazard_pkg::MEM_SD;
        mem_s.rs2   = 5'd7;
        wb_s.valid  = 1'b1;
        wb_s.wb_op  = hazard_pkg::WB_EXE;
        wb_s.rd     = 5'd7;
        apply_vector("store_rs2_vs_wb", mem_stall);
    endtask

    task automatic id_csr_reads();
        hazard_pkg::pipe_ctrl_t stall;
        stall = '{if_reg_enable: 1'b0, id_reg_enable: 1'b0, exe_reg_valid: 1'b0, default: 1'b1};
        clear_snapshot();
        id_s.valid  = 1'b1;
        id_s.op     = hazard_pkg::ID_MRET;
        mem_s.valid = 1'b1;
        mem_s.wb_op = hazard_pkg::WB_CSRRW;
        mem_s.rd    = 5'd2;
        mem_s.csr   = hazard_pkg::CSR_MEPC;
        apply_vector("mret_vs_mem_csrrw", stall);
        mem_s.csr   = hazard_pkg::CSR_MSTATUS;
        apply_vector("mret_vs_mstatus_write", CTRL_IDLE);
        clear_snapshot();
        id_s.valid = 1'b1;
        id_s.op    = hazard_pkg::ID_ECALL;
        wb_s.valid = 1'b1;
        wb_s.wb_op = hazard_pkg::WB_CSRRWI;
        wb_s.csr   = hazard_pkg::CSR_MTVEC;
        apply_vector("ecall_vs_wb_mtvec", stall);
    endtask

    task automatic flow_controls();
        clear_snapshot();
        id_s.valid  = 1'b1;
        id_s.op     = hazard_pkg::ID_FENCE_I;
        exe_s.valid = 1'b1; // nop still in flight
        apply_vector("fence_i_wait", '{if_reg_enable: 1'b0, if_valid: 1'b0,
                                      id_reg_enable: 1'b0, exe_reg_valid: 1'b0, default: 1'b1});
        exe_s.valid = 1'b0;
        apply_vector("fence_i_drained", '{exe_reg_valid: 1'b0, default: 1'b1});
        id_s.op = hazard_pkg::ID_EBREAK;
        apply_vector("ebreak_bubble", '{exe_reg_valid: 1'b0, default: 1'b1});
        id_s.op    = hazard_pkg::ID_NONE;
        redirect_s = 1'b1;
        apply_vector("redirect_kill", '{if_valid: 1'b0, id_reg_valid: 1'b0, default: 1'b1});
        id_s.valid = 1'b0;
        apply_vector("redirect_no_id", CTRL_IDLE);
        clear_snapshot();
        mem_ok_s = 1'b0;
        apply_vector("mem_busy", '{if_reg_enable: 1'b0, id_reg_enable: 1'b0,
                                  exe_reg_enable: 1'b0, mem_reg_enable: 1'b0, default: 1'b1});
        clear_snapshot();
        if_ok_s = 1'b0;
        apply_vector("fetch_busy", '{if_reg_enable: 1'b0, default: 1'b1});
    endtask

    task automatic random_sweep();
        hazard_pkg::pipe_ctrl_t expected;
        int                     i;
        for (i = 0; i < N_RANDOM; i++) begin
            id_s.valid  = 1'(rand_bits(1));
            id_s.op     = hazard_pkg::id_op_e'(4'(rand_bits(3)));
            id_s.rs1    = 5'(rand_bits(2)); // narrow indices so matches are common
            id_s.rs2    = 5'(rand_bits(2));
            exe_s.valid = 1'(rand_bits(1));
            exe_s.op    = (rand_bits(1) != 0) ? hazard_pkg::EXE_ADD : hazard_pkg::EXE_NOP;
            exe_s.src   = hazard_pkg::exe_src_e'(3'(rand_bits(3)));
            exe_s.wb_op = hazard_pkg::wb_op_e'(4'(rand_bits(4) % 11));
            exe_s.rd    = 5'(rand_bits(2));
            exe_s.rs1   = 5'(rand_bits(2));
            exe_s.rs2   = 5'(rand_bits(2));
            exe_s.csr   = pick_csr();
            mem_s.valid = 1'(rand_bits(1));
            mem_s.op    = hazard_pkg::mem_op_e'(4'(rand_bits(4) % 12));
            mem_s.wb_op = hazard_pkg::wb_op_e'(4'(rand_bits(4) % 11));
            mem_s.rd    = 5'(rand_bits(2));
            mem_s.rs2   = 5'(rand_bits(2));
            mem_s.csr   = pick_csr();
            wb_s.valid  = 1'(rand_bits(1));
            wb_s.wb_op  = hazard_pkg::wb_op_e'(4'(rand_bits(4) % 11));
            wb_s.rd     = 5'(rand_bits(2));
            wb_s.csr    = pick_csr();
            redirect_s  = 1'(rand_bits(1));
            mem_ok_s    = |rand_bits(2);
            if_ok_s     = |rand_bits(2);
            expected = model_ctrl(id_s, exe_s, mem_s, wb_s, redirect_s, mem_ok_s, if_ok_s);
            apply_vector($sformatf("random_sweep[%0d]", i), expected);
        end
    endtask

    initial begin
        lfsr_state = 32'hd9d8026b;
        clear_snapshot();
        id          = id_s;
        exe         = exe_s;
        mem         = mem_s;
        wb          = wb_s;
        if_redirect = redirect_s;
        mem_ok      = mem_ok_s;
        if_ok       = if_ok_s;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            #(CLK_PERIOD - 2);
            check_pipe_ctrl("idle_in_reset", CTRL_IDLE, ctrl);
        end
        idle_check();
        id_reg_hazards();
        exe_mem_hazards();
        id_csr_reads();
        flow_controls();
        random_sweep();
        $display("PASS: all tests");
        $finish;
    end

endmodule
